//--- compile.f
common/lpif_pkg.sv
common/lpif_sync_if.sv
hdl/lpif_apb_regs.sv
hdl/ll_auto_sync.sv
hdl/lpif_user_pack.sv
hdl/lpif_phy_concat.sv
hdl/lpif_link_top.sv
verification/clk_gen.sv
verification/lpif_link_props.sv
verification/tb_lpif_link.sv

//--- Makefile
TOP = tb_lpif_link

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f compile.f

# Pass only when the pass message appears in the output
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- verification/tb_lpif_link.sv
////////////////////////////////////////////////////////////
// Transmit lanes looped back to the receive lanes
// Checking lives in the bound props module
////////////////////////////////////////////////////////////

module tb_lpif_link;

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        tx_online;
  logic        rx_online;
  logic [39:0] tx_phy0;
  logic [39:0] tx_phy1;
  logic [3:0]  ustrm_state;
  logic [1:0]  ustrm_protid;
  logic [31:0] ustrm_data;
  logic        ustrm_dvalid;
  logic [15:0] ustrm_crc;
  logic        ustrm_crc_valid;
  logic        ustrm_valid;
  logic [3:0]  dstrm_state;
  logic [1:0]  dstrm_protid;
  logic [31:0] dstrm_data;
  logic        dstrm_dvalid;
  logic [15:0] dstrm_crc;
  logic        dstrm_crc_valid;
  logic        dstrm_valid;
  int          timeouts;

  clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  lpif_link_top dut (
    .clk_wr(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .tx_online(tx_online), .rx_online(rx_online),
    .tx_phy0(tx_phy0), .tx_phy1(tx_phy1), .rx_phy0(tx_phy0), .rx_phy1(tx_phy1),
    .ustrm_state(ustrm_state), .ustrm_protid(ustrm_protid), .ustrm_data(ustrm_data),
    .ustrm_dvalid(ustrm_dvalid), .ustrm_crc(ustrm_crc),
    .ustrm_crc_valid(ustrm_crc_valid), .ustrm_valid(ustrm_valid),
    .dstrm_state(dstrm_state), .dstrm_protid(dstrm_protid), .dstrm_data(dstrm_data),
    .dstrm_dvalid(dstrm_dvalid), .dstrm_crc(dstrm_crc),
    .dstrm_crc_valid(dstrm_crc_valid), .dstrm_valid(dstrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // APB and flit tasks
  ////////////////////////////////////////////////////////////

  // Setup, access, then wait for pready
  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (!pready && waited < 16) begin
      waited++;
      @(posedge clk);
    end
    if (!pready) begin
      $display("Timeout: APB slave never raised pready");
      timeouts++;
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // One random flit per cycle
  task automatic send_flits(input int n);
    repeat (n) begin
      @(posedge clk);
      ustrm_state     <= 4'($urandom);
      ustrm_protid    <= 2'($urandom);
      ustrm_data      <= $urandom;
      ustrm_dvalid    <= 1'($urandom);
      ustrm_crc       <= 16'($urandom);
      ustrm_crc_valid <= 1'($urandom);
      ustrm_valid     <= 1'($urandom);
    end
  endtask

  // Lane 0 strobe shows the transmit side is online
  task automatic wait_lane_strobe();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!tx_phy0[38] && waited < 64) begin
      waited++;
      send_flits(1);
    end
    if (!tx_phy0[38]) begin
      $display("Timeout: lane 0 strobe never went high");
      timeouts++;
    end
  endtask

  // Bring the link up with random delays
  task automatic link_up(input logic gen2);
    logic [31:0] ctrl;
    ctrl = {7'h0, gen2, 8'($urandom_range(0, 6)), 8'($urandom_range(0, 6)),
            8'($urandom_range(0, 6))};
    apb_access(1'b1, 8'h00, ctrl);
    apb_access(1'b0, 8'h00, 32'h0);
    apb_access(1'b1, 8'h04, {29'h0, 1'b1, 2'($urandom)});
    apb_access(1'b0, 8'h04, 32'h0);
    @(posedge clk);
    tx_online <= 1'b1;
    // Receive stays offline while data already flows
    send_flits(6);
    rx_online <= 1'b1;
    wait_lane_strobe();
    send_flits(50);
  endtask

  initial begin
    int waited;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 8'h00;
    pwdata = 32'h0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid} = '0;
    {ustrm_crc, ustrm_crc_valid, ustrm_valid} = '0;
    timeouts = 0;
    waited = 0;
    void'($urandom(82));
    while (rst_n !== 1'b1 && waited < 20) begin
      waited++;
      @(posedge clk);
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
    send_flits(4);
    // Register map, error responses included
    apb_access(1'b1, 8'h00, $urandom);
    apb_access(1'b0, 8'h00, 32'h0);
    apb_access(1'b1, 8'h04, $urandom);
    apb_access(1'b0, 8'h04, 32'h0);
    apb_access(1'b1, 8'h08, $urandom);
    apb_access(1'b1, 8'h0C, $urandom);
    apb_access(1'b0, 8'h10, 32'h0);
    apb_access(1'b1, 8'h20, $urandom);
    apb_access(1'b0, 8'h03, 32'h0);
    // Generation 1, then generation 2
    link_up(1'b0);
    apb_access(1'b0, 8'h08, 32'h0);
    apb_access(1'b0, 8'h0C, 32'h0);
    @(posedge clk);
    tx_online <= 1'b0;
    rx_online <= 1'b0;
    send_flits(4);
    link_up(1'b1);
    apb_access(1'b0, 8'h08, 32'h0);
    apb_access(1'b0, 8'h0C, 32'h0);
    send_flits(4);
    $display("Errors: assertions %0d, timeouts %0d", dut.u_props.err_cnt, timeouts);
    if (dut.u_props.err_cnt == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Run length limit
  initial begin
    #500us;
    $display("Simulation ran past its time limit");
    $display("Checks failed");
    $finish;
  end

endmodule

//--- verification/lpif_link_props.sv
////////////////////////////////////////////////////////////
// Reference model built from APB writes and online inputs
// Delays must not be reprogrammed while a link is online
////////////////////////////////////////////////////////////

module lpif_link_props
  import lpif_pkg::*;
(
  input logic                clk_wr,
  input logic                rst_n,
  input logic                psel,
  input logic                penable,
  input logic                pwrite,
  input logic [7:0]          paddr,
  input logic [31:0]         pwdata,
  input logic [31:0]         prdata,
  input logic                pready,
  input logic                pslverr,
  input logic                tx_online,
  input logic                rx_online,
  input logic [lane_w-1:0]   tx_phy0,
  input logic [lane_w-1:0]   tx_phy1,
  input logic [state_w-1:0]  ustrm_state,
  input logic [protid_w-1:0] ustrm_protid,
  input logic [data_w-1:0]   ustrm_data,
  input logic                ustrm_dvalid,
  input logic [crc_w-1:0]    ustrm_crc,
  input logic                ustrm_crc_valid,
  input logic                ustrm_valid,
  input logic [state_w-1:0]  dstrm_state,
  input logic [protid_w-1:0] dstrm_protid,
  input logic [data_w-1:0]   dstrm_data,
  input logic                dstrm_dvalid,
  input logic [crc_w-1:0]    dstrm_crc,
  input logic                dstrm_crc_valid,
  input logic                dstrm_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [24:0]       sh_ctrl;
  logic [2:0]        sh_user;
  logic [9:0]        tx_age;
  logic [9:0]        rx_age;
  logic              tx_ready;
  logic              rx_ready;
  logic              access;
  logic              exp_err;
  logic [flit_w-1:0] exp_word;
  logic [flit_w-1:0] word_q1;
  logic [flit_w-1:0] word_q2;
  logic [flit_w-1:0] act_word;
  logic [flit_w-1:0] exp_dstrm;
  logic [lane_w-1:0] exp_phy0;
  logic [lane_w-1:0] exp_phy1;
  logic [lane_w-1:0] phy0_q;
  logic [lane_w-1:0] phy1_q;
  logic              stb_on_q;
  logic              ok_q;
  logic [31:0]       tx_cnt_m;
  logic [31:0]       rx_cnt_m;
  int                err_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////

  always_comb begin
    access   = psel && penable;
    exp_err  = !(paddr inside {reg_ctrl, reg_userbits, reg_tx_count, reg_rx_count}) ||
               (pwrite && (paddr == reg_tx_count || paddr == reg_rx_count));
    // Online once the cycles since the rise reach the delay
    tx_ready = tx_online && (tx_age >= {2'b0, sh_ctrl[15:8]});
    rx_ready = rx_online && (rx_age >= ({2'b0, sh_ctrl[7:0]} + {2'b0, sh_ctrl[23:16]}));
    exp_word = {ustrm_valid, ustrm_crc_valid, ustrm_crc, ustrm_dvalid,
                sh_ctrl[24] ? ustrm_data : {16'h0, ustrm_data[15:0]},
                ustrm_protid, ustrm_state};
    exp_phy0 = tx_ready ? {sh_user[0], sh_user[2], exp_word[37:0]} : '0;
    exp_phy1 = tx_ready ? {sh_user[1], 20'h0, exp_word[56:38]} : '0;
    act_word = {dstrm_valid, dstrm_crc_valid, dstrm_crc, dstrm_dvalid,
                dstrm_data, dstrm_protid, dstrm_state};
    // Loopback word shows up two cycles later if qualified
    exp_dstrm = ok_q ? word_q2 : '0;
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      sh_ctrl  <= '0;
      sh_user  <= '0;
      tx_age   <= '0;
      rx_age   <= '0;
      word_q1  <= '0;
      word_q2  <= '0;
      phy0_q   <= '0;
      phy1_q   <= '0;
      stb_on_q <= 1'b0;
      ok_q     <= 1'b0;
      tx_cnt_m <= '0;
      rx_cnt_m <= '0;
    end else begin
      if (access && pwrite && paddr == reg_ctrl) begin
        sh_ctrl <= pwdata[24:0];
      end
      if (access && pwrite && paddr == reg_userbits) begin
        sh_user <= pwdata[2:0];
      end
      tx_age   <= !tx_online ? '0 : (tx_age == '1 ? tx_age : tx_age + 10'd1);
      rx_age   <= !rx_online ? '0 : (rx_age == '1 ? rx_age : rx_age + 10'd1);
      word_q1  <= exp_word;
      word_q2  <= word_q1;
      phy0_q   <= exp_phy0;
      phy1_q   <= exp_phy1;
      stb_on_q <= tx_ready && sh_user[2];
      ok_q     <= stb_on_q && rx_ready;
      tx_cnt_m <= tx_cnt_m + {31'd0, ustrm_valid && tx_ready};
      rx_cnt_m <= rx_cnt_m + {31'd0, exp_dstrm[flit_w-1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_pready: assert property (@(posedge clk_wr) disable iff (!rst_n) psel |-> pready)
    else begin $error("pready low during an APB transfer"); err_cnt++; end
  a_pslverr: assert property (@(posedge clk_wr) disable iff (!rst_n)
      access |-> pslverr == exp_err)
    else begin $error("Mismatch pslverr got %h exp %h", pslverr, exp_err); err_cnt++; end
  a_idle_err: assert property (@(posedge clk_wr) disable iff (!rst_n) !access |-> !pslverr)
    else begin $error("pslverr high outside an access cycle"); err_cnt++; end
  a_rd_ctrl: assert property (@(posedge clk_wr) disable iff (!rst_n)
      (access && !pwrite && paddr == reg_ctrl) |-> prdata == {7'h0, sh_ctrl})
    else begin $error("Mismatch prdata ctrl got %h exp %h", prdata, sh_ctrl); err_cnt++; end
  a_rd_user: assert property (@(posedge clk_wr) disable iff (!rst_n)
      (access && !pwrite && paddr == reg_userbits) |-> prdata == {29'h0, sh_user})
    else begin $error("Mismatch prdata userbits got %h exp %h", prdata, sh_user); err_cnt++; end
  a_rd_tx: assert property (@(posedge clk_wr) disable iff (!rst_n)
      (access && !pwrite && paddr == reg_tx_count) |-> prdata == tx_cnt_m)
    else begin $error("Mismatch tx_count got %h exp %h", prdata, tx_cnt_m); err_cnt++; end
  a_rd_rx: assert property (@(posedge clk_wr) disable iff (!rst_n)
      (access && !pwrite && paddr == reg_rx_count) |-> prdata == rx_cnt_m)
    else begin $error("Mismatch rx_count got %h exp %h", prdata, rx_cnt_m); err_cnt++; end

  // Lane contents, online delay and marker bits
  a_phy0: assert property (@(posedge clk_wr) disable iff (!rst_n) tx_phy0 == phy0_q)
    else begin $error("Mismatch tx_phy0 got %h exp %h", tx_phy0, phy0_q); err_cnt++; end
  a_phy1: assert property (@(posedge clk_wr) disable iff (!rst_n) tx_phy1 == phy1_q)
    else begin $error("Mismatch tx_phy1 got %h exp %h", tx_phy1, phy1_q); err_cnt++; end

  // Loopback data and receive qualification
  a_dstrm: assert property (@(posedge clk_wr) disable iff (!rst_n) act_word == exp_dstrm)
    else begin $error("Mismatch dstrm flit got %h exp %h", act_word, exp_dstrm); err_cnt++; end

  a_reset: assert property (@(posedge clk_wr) !rst_n |=>
      (tx_phy0 == '0 && tx_phy1 == '0 && !dstrm_valid && !pslverr))
    else begin $error("Outputs not quiet during or after reset"); err_cnt++; end

endmodule

bind lpif_link_top lpif_link_props u_props (.*);

//--- verification/clk_gen.sv
////////////////////////////////////////////////////////////
// 40 ns clock, rst_n low for the first 4 rising edges
////////////////////////////////////////////////////////////

module clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Synchronous release on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- hdl/lpif_link_top.sv
////////////////////////////////////////////////////////////
// Single clock domain, no back-pressure, one flit per cycle
// Lane loopback gives 2 cycles from upstream to downstream
////////////////////////////////////////////////////////////

module lpif_link_top
  import lpif_pkg::*;
(
  input  logic                clk_wr,
  input  logic                rst_n,
  // APB configuration port
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [7:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  // Link control
  input  logic                tx_online,
  input  logic                rx_online,
  // PHY lanes
  output logic [lane_w-1:0]   tx_phy0,
  output logic [lane_w-1:0]   tx_phy1,
  input  logic [lane_w-1:0]   rx_phy0,
  input  logic [lane_w-1:0]   rx_phy1,
  // Upstream channel
  input  logic [state_w-1:0]  ustrm_state,
  input  logic [protid_w-1:0] ustrm_protid,
  input  logic [data_w-1:0]   ustrm_data,
  input  logic                ustrm_dvalid,
  input  logic [crc_w-1:0]    ustrm_crc,
  input  logic                ustrm_crc_valid,
  input  logic                ustrm_valid,
  // Downstream channel
  output logic [state_w-1:0]  dstrm_state,
  output logic [protid_w-1:0] dstrm_protid,
  output logic [data_w-1:0]   dstrm_data,
  output logic                dstrm_dvalid,
  output logic [crc_w-1:0]    dstrm_crc,
  output logic                dstrm_crc_valid,
  output logic                dstrm_valid
);

  // Configuration wires
  logic [delay_w-1:0] delay_x;
  logic [delay_w-1:0] delay_xz;
  logic [delay_w-1:0] delay_yz;
  logic [mrk_w-1:0]   mrk_userbit;
  logic               stb_userbit;
  logic               gen2_mode;
  // Count events
  logic               tx_flit_pulse;
  logic               rx_flit_pulse;
  // Flit words
  flit_u              tx_word;
  flit_u              rx_word;
  logic               rx_word_ok;

  lpif_sync_if sync_if ();

  ////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////

  lpif_apb_regs u_apb_regs (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .tx_flit_pulse (tx_flit_pulse),
    .rx_flit_pulse (rx_flit_pulse),
    .delay_x       (delay_x),
    .delay_xz      (delay_xz),
    .delay_yz      (delay_yz),
    .mrk_userbit   (mrk_userbit),
    .stb_userbit   (stb_userbit),
    .gen2_mode     (gen2_mode)
  );

  // Online delays and marker/strobe
  ll_auto_sync u_auto_sync (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online),
    .rx_online   (rx_online),
    .delay_x     (delay_x),
    .delay_xz    (delay_xz),
    .delay_yz    (delay_yz),
    .mrk_userbit (mrk_userbit),
    .stb_userbit (stb_userbit),
    .sync        (sync_if.sync)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  lpif_user_pack u_user_pack (
    .gen2_mode       (gen2_mode),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok),
    .tx_online_delay (sync_if.tx_online_delay),
    .tx_flit_pulse   (tx_flit_pulse),
    .rx_flit_pulse   (rx_flit_pulse)
  );

  lpif_phy_concat u_phy_concat (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .tx_word    (tx_word),
    .rx_word    (rx_word),
    .rx_word_ok (rx_word_ok),
    .tx_phy0    (tx_phy0),
    .tx_phy1    (tx_phy1),
    .rx_phy0    (rx_phy0),
    .rx_phy1    (rx_phy1),
    .sync       (sync_if.phy)
  );

endmodule

//--- hdl/lpif_phy_concat.sv
////////////////////////////////////////////////////////////
// One register stage per direction, lanes zero while offline
// Bit 39 marker per lane, bit 38 strobe on lane 0 only
////////////////////////////////////////////////////////////

module lpif_phy_concat
  import lpif_pkg::*;
(
  input  logic              clk_wr,
  input  logic              rst_n,
  // Flit words
  input  flit_u             tx_word,
  output flit_u             rx_word,
  output logic              rx_word_ok,
  // PHY lanes
  output logic [lane_w-1:0] tx_phy0,
  output logic [lane_w-1:0] tx_phy1,
  input  logic [lane_w-1:0] rx_phy0,
  input  logic [lane_w-1:0] rx_phy1,
  lpif_sync_if.phy          sync
);

  ////////////////////////////////////////////////////////////
  // Transmit stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (sync.tx_online_delay) begin
      // Lane 0: low 38 raw bits under marker and strobe
      tx_phy0 <= {sync.tx_auto_mrk[0], sync.tx_auto_stb,
                  tx_word.raw[lane_payload_w-1:0]};
      // Lane 1: upper 19 raw bits, rest of payload zero
      tx_phy1 <= {sync.tx_auto_mrk[1], 1'b0,
                  {(2*lane_payload_w-flit_w){1'b0}},
                  tx_word.raw[flit_w-1:lane_payload_w]};
    end else begin
      // Quiet lanes before online
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive stage
  ////////////////////////////////////////////////////////////

  // Qualifier: lane 0 strobe while receive is online
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_word_ok <= 1'b0;
    end else begin
      rx_word_ok <= sync.rx_online_delay & rx_phy0[lane_payload_w];
    end
  end

  // Reassemble the raw word from both lanes
  always_ff @(posedge clk_wr) begin
    rx_word.raw <= {rx_phy1[flit_w-lane_payload_w-1:0],
                    rx_phy0[lane_payload_w-1:0]};
  end

endmodule

//--- hdl/lpif_user_pack.sv
////////////////////////////////////////////////////////////
// Purely combinational; unqualified receive words read as zero
////////////////////////////////////////////////////////////

module lpif_user_pack
  import lpif_pkg::*;
(
  input  logic                gen2_mode,
  // Upstream user fields
  input  logic [state_w-1:0]  ustrm_state,
  input  logic [protid_w-1:0] ustrm_protid,
  input  logic [data_w-1:0]   ustrm_data,
  input  logic                ustrm_dvalid,
  input  logic [crc_w-1:0]    ustrm_crc,
  input  logic                ustrm_crc_valid,
  input  logic                ustrm_valid,
  // Downstream user fields
  output logic [state_w-1:0]  dstrm_state,
  output logic [protid_w-1:0] dstrm_protid,
  output logic [data_w-1:0]   dstrm_data,
  output logic                dstrm_dvalid,
  output logic [crc_w-1:0]    dstrm_crc,
  output logic                dstrm_crc_valid,
  output logic                dstrm_valid,
  // Flit words to and from the PHY block
  output flit_u               tx_word,
  input  flit_u               rx_word,
  input  logic                rx_word_ok,
  input  logic                tx_online_delay,
  // Count events
  output logic                tx_flit_pulse,
  output logic                rx_flit_pulse
);

  // Transmit packing
  always_comb begin
    tx_word.f.valid     = ustrm_valid;
    tx_word.f.crc_valid = ustrm_crc_valid;
    tx_word.f.crc       = ustrm_crc;
    tx_word.f.dvalid    = ustrm_dvalid;
    // Gen1 carries only the low half of data
    tx_word.f.data      = gen2_mode ? ustrm_data
                                    : {{(data_w/2){1'b0}}, ustrm_data[data_w/2-1:0]};
    tx_word.f.protid    = ustrm_protid;
    tx_word.f.state     = ustrm_state;
  end

  // Receive unpacking, zero unless qualified
  always_comb begin
    dstrm_valid     = rx_word_ok & rx_word.f.valid;
    dstrm_crc_valid = rx_word_ok & rx_word.f.crc_valid;
    dstrm_crc       = rx_word_ok ? rx_word.f.crc : '0;
    dstrm_dvalid    = rx_word_ok & rx_word.f.dvalid;
    dstrm_data      = rx_word_ok ? rx_word.f.data : '0;
    dstrm_protid    = rx_word_ok ? rx_word.f.protid : '0;
    dstrm_state     = rx_word_ok ? rx_word.f.state : '0;
  end

  // Only flits sent while online count
  assign tx_flit_pulse = ustrm_valid & tx_online_delay;
  assign rx_flit_pulse = dstrm_valid;

endmodule

//--- hdl/ll_auto_sync.sv
////////////////////////////////////////////////////////////
// Zero delay brings the online flag up in the same cycle
// Delayed flags drop as soon as their online input drops
////////////////////////////////////////////////////////////

module ll_auto_sync
  import lpif_pkg::*;
(
  input  logic               clk_wr,
  input  logic               rst_n,
  input  logic               tx_online,
  input  logic               rx_online,
  // Programmed delays
  input  logic [delay_w-1:0] delay_x,
  input  logic [delay_w-1:0] delay_xz,
  input  logic [delay_w-1:0] delay_yz,
  // Persistent user bits
  input  logic [mrk_w-1:0]   mrk_userbit,
  input  logic               stb_userbit,
  lpif_sync_if.sync          sync
);

  // Index 0 is transmit, index 1 is receive
  logic [1:0]                  online;
  logic [1:0]                  online_q;
  logic [1:0][sync_cnt_w-1:0]  dly;
  logic [1:0][sync_cnt_w-1:0]  cnt_q;
  logic [1:0][sync_cnt_w-1:0]  cnt_now;
  logic [1:0]                  online_dly;

  ////////////////////////////////////////////////////////////
  // Delay counters
  ////////////////////////////////////////////////////////////

  always_comb begin
    online = {rx_online, tx_online};
    dly[0] = {1'b0, delay_xz};
    // Receive waits for alignment time plus its own delay
    dly[1] = {1'b0, delay_x} + {1'b0, delay_yz};
    for (int i = 0; i < 2; i++) begin
      // Load on the rising edge, else keep counting
      cnt_now[i]    = (online[i] && !online_q[i]) ? dly[i] : cnt_q[i];
      online_dly[i] = online[i] && (cnt_now[i] == '0);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      online_q <= '0;
      cnt_q    <= '0;
    end else begin
      online_q <= online;
      for (int i = 0; i < 2; i++) begin
        // Count down to zero and hold there
        if (online[i] && (cnt_now[i] != '0)) begin
          cnt_q[i] <= cnt_now[i] - 1'b1;
        end else begin
          cnt_q[i] <= '0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign sync.tx_online_delay = online_dly[0];
  assign sync.rx_online_delay = online_dly[1];

  // Marker and strobe only while transmit is online
  assign sync.tx_auto_mrk = online_dly[0] ? mrk_userbit : '0;
  assign sync.tx_auto_stb = online_dly[0] & stb_userbit;

endmodule

//--- hdl/lpif_apb_regs.sv
////////////////////////////////////////////////////////////
// Zero-wait-state APB slave, pready follows psel
// Counters are read-only and wrap at 32 bits
////////////////////////////////////////////////////////////

module lpif_apb_regs
  import lpif_pkg::*;
(
  input  logic               clk_wr,
  input  logic               rst_n,
  // APB slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [7:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  // Flit count events
  input  logic               tx_flit_pulse,
  input  logic               rx_flit_pulse,
  // Configuration
  output logic [delay_w-1:0] delay_x,
  output logic [delay_w-1:0] delay_xz,
  output logic [delay_w-1:0] delay_yz,
  output logic [mrk_w-1:0]   mrk_userbit,
  output logic               stb_userbit,
  output logic               gen2_mode
);

  logic [31:0] tx_count;
  logic [31:0] rx_count;
  logic        access;
  logic        addr_hit;
  logic        wr_ro;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  // Access phase of a transfer
  assign access = psel & penable;

  always_comb begin
    addr_hit = (paddr == reg_ctrl) || (paddr == reg_userbits) ||
               (paddr == reg_tx_count) || (paddr == reg_rx_count);
  end

  // Counts are read-only
  assign wr_ro = pwrite & ((paddr == reg_tx_count) || (paddr == reg_rx_count));

  // No wait states
  assign pready  = psel;
  assign pslverr = access & (~addr_hit | wr_ro);

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      delay_x     <= '0;
      delay_xz    <= '0;
      delay_yz    <= '0;
      gen2_mode   <= 1'b0;
      mrk_userbit <= '0;
      stb_userbit <= 1'b0;
    end else if (access && pwrite) begin
      // Write lands in the access cycle
      if (paddr == reg_ctrl) begin
        delay_x   <= pwdata[delay_w-1:0];
        delay_xz  <= pwdata[2*delay_w-1:delay_w];
        delay_yz  <= pwdata[3*delay_w-1:2*delay_w];
        gen2_mode <= pwdata[3*delay_w];
      end
      if (paddr == reg_userbits) begin
        mrk_userbit <= pwdata[mrk_w-1:0];
        stb_userbit <= pwdata[mrk_w];
      end
    end
  end

  // Debug flit counters, free running
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_count <= '0;
      rx_count <= '0;
    end else begin
      if (tx_flit_pulse) begin
        tx_count <= tx_count + 32'd1;
      end
      if (rx_flit_pulse) begin
        rx_count <= rx_count + 32'd1;
      end
    end
  end

  // Read mux, valid in the access cycle
  always_comb begin
    case (paddr)
      reg_ctrl:     prdata = {{(32-3*delay_w-1){1'b0}}, gen2_mode, delay_yz, delay_xz, delay_x};
      reg_userbits: prdata = {{(32-mrk_w-1){1'b0}}, stb_userbit, mrk_userbit};
      reg_tx_count: prdata = tx_count;
      reg_rx_count: prdata = rx_count;
      default:      prdata = '0;
    endcase
  end

endmodule

//--- common/lpif_sync_if.sv
////////////////////////////////////////////////////////////
// Delayed online flags and persistent marker/strobe bits
////////////////////////////////////////////////////////////

interface lpif_sync_if
  import lpif_pkg::*;
();

  // Transmit side online after programmed delay
  logic             tx_online_delay;
  // Receive side online after programmed delay
  logic             rx_online_delay;
  // Marker bits, one per lane
  logic [mrk_w-1:0] tx_auto_mrk;
  // Lane 0 strobe
  logic             tx_auto_stb;

  // Auto-sync side
  modport sync (
    output tx_online_delay,
    output rx_online_delay,
    output tx_auto_mrk,
    output tx_auto_stb
  );

  // PHY concatenation side
  modport phy (
    input tx_online_delay,
    input rx_online_delay,
    input tx_auto_mrk,
    input tx_auto_stb
  );

endinterface

//--- common/lpif_pkg.sv
////////////////////////////////////////////////////////////
// Scaled link widths: 32-bit data, 16-bit CRC, 2 lanes
// Flit word is 57 bits, split 38 + 19 across the lanes
////////////////////////////////////////////////////////////

package lpif_pkg;

  // Flit field widths
  localparam int data_w   = 32;
  localparam int crc_w    = 16;
  localparam int state_w  = 4;
  localparam int protid_w = 2;

  // valid + crc_valid + crc + dvalid + data + protid + state
  localparam int flit_w = 57;

  // PHY lane layout
  localparam int lane_w         = 40;
  localparam int lane_payload_w = 38;
  // One marker bit per lane
  localparam int mrk_w          = 2;

  // Online delay programming
  localparam int delay_w    = 8;
  // Receive delay is a sum of two fields, one extra bit
  localparam int sync_cnt_w = delay_w + 1;

  // APB register offsets
  localparam logic [7:0] reg_ctrl     = 8'h00;
  localparam logic [7:0] reg_userbits = 8'h04;
  localparam logic [7:0] reg_tx_count = 8'h08;
  localparam logic [7:0] reg_rx_count = 8'h0C;

  ////////////////////////////////////////////////////////////
  // Flit word, seen as fields or as raw lane bits
  ////////////////////////////////////////////////////////////
  typedef union packed {
    // Field view, top bit down
    struct packed {
      logic                valid;
      logic                crc_valid;
      logic [crc_w-1:0]    crc;
      logic                dvalid;
      logic [data_w-1:0]   data;
      logic [protid_w-1:0] protid;
      logic [state_w-1:0]  state;
    } f;
    // Raw view, sliced across lanes
    logic [flit_w-1:0] raw;
  } flit_u;

endpackage
